//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert
TOP       ?= issueCoreTb
FILELIST  ?= src.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

obj_dir/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- source/dispatchUnit.sv
`default_nettype none
`timescale 1ns/100ps

`include "issueQueue_defines.svh"

module dispatchUnit (
	input  logic                       clk,
	input  logic                       rst_i,
	input  logic                       dispatch_i,
	input  logic [`QUEUE_DEPTH-1:0]    entryValid_i,
	output logic                       write_o,
	output queuePkg::slotIdx_t         writeSlot_o,
	output queuePkg::ageTag_t          writeAge_o,
	output logic                       full_o
);

	import queuePkg::*;

	logic [`QUEUE_DEPTH-1:0] freeSlots;
	logic [`QUEUE_DEPTH-1:0] firstFree;
	logic [`AGE_WIDTH-1:0]   ageCount;
	logic                    ageWrap;
	logic [`AGE_WIDTH:0]     ageSum;

	assign freeSlots = ~entryValid_i;

	// lowest free slot wins
	for (genvar i = 0; i < `QUEUE_DEPTH; i++) begin : gFree
		if (i == 0) begin : gFirst
			assign firstFree[i] = freeSlots[i];
		end else begin : gRest
			assign firstFree[i] = freeSlots[i] & ~|freeSlots[i-1:0];
		end
	end

	// one-hot to index
	always_comb begin
		writeSlot_o = '0;
		for (int i = 0; i < `QUEUE_DEPTH; i++) begin
			if (firstFree[i]) begin
				writeSlot_o = writeSlot_o | slotIdx_t'(i);
			end
		end
	end

	assign full_o = ~|freeSlots;

	// a strobe while full is dropped
	assign write_o = dispatch_i & ~full_o;

	// carry out of the counter flips the wrap bit
	assign ageSum = {1'b0, ageCount} + (`AGE_WIDTH+1)'(1);

	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			ageCount <= '0;
			ageWrap  <= 1'b0;
		end else if (write_o) begin
			ageCount <= ageSum[`AGE_WIDTH-1:0];
			ageWrap  <= ageWrap ^ ageSum[`AGE_WIDTH];
		end
	end

	assign writeAge_o = ageTag_t'({ageCount, ageWrap});

endmodule

`default_nettype wire

//--- source/issueBuffer.sv
`default_nettype none
`timescale 1ns/100ps

`include "issueQueue_defines.svh"

module issueBuffer (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      write_i,
	input  queuePkg::slotIdx_t        writeSlot_i,
	input  queuePkg::ageTag_t         writeAge_i,
	input  opPkg::aluOp_e             op_i,
	input  opPkg::operand_t           srcA_i,
	input  opPkg::operand_t           srcB_i,
	input  queuePkg::physTag_t        srcTag_i,
	input  queuePkg::physTag_t        destTag_i,
	input  logic                      srcReady_i,
	input  logic                      wakeup_i,
	input  queuePkg::physTag_t        wakeTag_i,
	input  logic                      issue_i,
	input  queuePkg::slotIdx_t        issueSlot_i,
	output logic [`QUEUE_DEPTH-1:0]   entryValid_o,
	output logic [`QUEUE_DEPTH-1:0]   entryReady_o,
	output queuePkg::ageTag_t         entryAge_o [`QUEUE_DEPTH],
	output opPkg::aluOp_e             entryOp_o [`QUEUE_DEPTH],
	output opPkg::operand_t           entryA_o [`QUEUE_DEPTH],
	output opPkg::operand_t           entryB_o [`QUEUE_DEPTH],
	output queuePkg::physTag_t        entryDest_o [`QUEUE_DEPTH]
);

	import queuePkg::*;

	physTag_t entrySrc [`QUEUE_DEPTH];
	logic     writeWake;

	// wakeup in the same edge as the write
	assign writeWake = wakeup_i && (wakeTag_i == srcTag_i);

	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			entryValid_o <= '0;
			entryReady_o <= '0;
		end else begin
			for (int i = 0; i < `QUEUE_DEPTH; i++) begin
				if (write_i && (writeSlot_i == slotIdx_t'(i))) begin
					entryValid_o[i] <= 1'b1;
					entryReady_o[i] <= srcReady_i | writeWake;
				end else begin
					if (issue_i && (issueSlot_i == slotIdx_t'(i))) begin
						entryValid_o[i] <= 1'b0;
					end
					// tag match on a waiting entry
					if (wakeup_i && entryValid_o[i] && (entrySrc[i] == wakeTag_i)) begin
						entryReady_o[i] <= 1'b1;
					end
				end
			end
		end
	end

	// payload only
	always_ff @(posedge clk) begin
		if (write_i) begin
			entryAge_o[writeSlot_i]  <= writeAge_i;
			entryOp_o[writeSlot_i]   <= op_i;
			entryA_o[writeSlot_i]    <= srcA_i;
			entryB_o[writeSlot_i]    <= srcB_i;
			entrySrc[writeSlot_i]    <= srcTag_i;
			entryDest_o[writeSlot_i] <= destTag_i;
		end
	end

endmodule

`default_nettype wire

//--- source/issueCore.sv
`default_nettype none
`timescale 1ns/100ps

`include "issueQueue_defines.svh"

module issueCore (
	input  logic                 clk,
	input  logic                 rst_i,
	input  logic                 dispatch_i,
	input  opPkg::aluOp_e        op_i,
	input  opPkg::operand_t      srcA_i,
	input  opPkg::operand_t      srcB_i,
	input  queuePkg::physTag_t   srcTag_i,
	input  logic                 srcReady_i,
	input  queuePkg::physTag_t   destTag_i,
	input  logic                 wakeup_i,
	input  queuePkg::physTag_t   wakeTag_i,
	output logic                 full_o,
	output logic                 resultValid_o,
	output queuePkg::physTag_t   resultTag_o,
	output opPkg::operand_t      resultData_o
);

	import opPkg::*;
	import queuePkg::*;

	logic                    rstSync;
	logic                    write;
	slotIdx_t                writeSlot;
	ageTag_t                 writeAge;
	logic                    issue;
	slotIdx_t                issueSlot;
	logic [`QUEUE_DEPTH-1:0] entryValid;
	logic [`QUEUE_DEPTH-1:0] entryReady;
	ageTag_t                 entryAge [`QUEUE_DEPTH];
	aluOp_e                  entryOp [`QUEUE_DEPTH];
	operand_t                entryA [`QUEUE_DEPTH];
	operand_t                entryB [`QUEUE_DEPTH];
	physTag_t                entryDest [`QUEUE_DEPTH];

	resetSync u_resetSync (
		.clk       (clk),
		.rst_i     (rst_i),
		.rstSync_o (rstSync)
	);

	dispatchUnit u_dispatch (
		.clk          (clk),
		.rst_i        (rstSync),
		.dispatch_i   (dispatch_i),
		.entryValid_i (entryValid),
		.write_o      (write),
		.writeSlot_o  (writeSlot),
		.writeAge_o   (writeAge),
		.full_o       (full_o)
	);

	// payload goes straight into the buffer
	issueBuffer u_buffer (
		.clk          (clk),
		.rst_i        (rstSync),
		.write_i      (write),
		.writeSlot_i  (writeSlot),
		.writeAge_i   (writeAge),
		.op_i         (op_i),
		.srcA_i       (srcA_i),
		.srcB_i       (srcB_i),
		.srcTag_i     (srcTag_i),
		.destTag_i    (destTag_i),
		.srcReady_i   (srcReady_i),
		.wakeup_i     (wakeup_i),
		.wakeTag_i    (wakeTag_i),
		.issue_i      (issue),
		.issueSlot_i  (issueSlot),
		.entryValid_o (entryValid),
		.entryReady_o (entryReady),
		.entryAge_o   (entryAge),
		.entryOp_o    (entryOp),
		.entryA_o     (entryA),
		.entryB_o     (entryB),
		.entryDest_o  (entryDest)
	);

	issueSelect u_select (
		.clk           (clk),
		.rst_i         (rstSync),
		.entryValid_i  (entryValid),
		.entryReady_i  (entryReady),
		.entryAge_i    (entryAge),
		.entryOp_i     (entryOp),
		.entryA_i      (entryA),
		.entryB_i      (entryB),
		.entryDest_i   (entryDest),
		.issue_o       (issue),
		.issueSlot_o   (issueSlot),
		.resultValid_o (resultValid_o),
		.resultTag_o   (resultTag_o),
		.resultData_o  (resultData_o)
	);

endmodule

`default_nettype wire

//--- source/issueQueue_defines.svh
`ifndef ISSUE_QUEUE_DEFINES_SVH
`define ISSUE_QUEUE_DEFINES_SVH

// number of issue buffer entries
`define QUEUE_DEPTH 8

// operand and result width
`define DATA_WIDTH 8

// physical register tag width
`define TAG_WIDTH 3

// age counter width, wrap bit not included
`define AGE_WIDTH 3

`endif

//--- source/issueSelect.sv
`default_nettype none
`timescale 1ns/100ps

`include "issueQueue_defines.svh"

module issueSelect (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic [`QUEUE_DEPTH-1:0]   entryValid_i,
	input  logic [`QUEUE_DEPTH-1:0]   entryReady_i,
	input  queuePkg::ageTag_t         entryAge_i [`QUEUE_DEPTH],
	input  opPkg::aluOp_e             entryOp_i [`QUEUE_DEPTH],
	input  opPkg::operand_t           entryA_i [`QUEUE_DEPTH],
	input  opPkg::operand_t           entryB_i [`QUEUE_DEPTH],
	input  queuePkg::physTag_t        entryDest_i [`QUEUE_DEPTH],
	output logic                      issue_o,
	output queuePkg::slotIdx_t        issueSlot_o,
	output logic                      resultValid_o,
	output queuePkg::physTag_t        resultTag_o,
	output opPkg::operand_t           resultData_o
);

	import opPkg::*;
	import queuePkg::*;

	localparam int NODES = 2 * `QUEUE_DEPTH - 1;

	logic [NODES-1:0] nodeValid;
	ageTag_t          nodeAge [NODES];
	slotIdx_t         nodeIdx [NODES];
	aluOp_e           aluOp;
	operand_t         opA;
	operand_t         opB;
	operand_t         aluOut;

	// a older than b, wrap bits decide the sense of the compare
	function automatic logic isOlder(input ageTag_t a, input ageTag_t b);
		return (a[0] ^ b[0]) ^ (a[`AGE_WIDTH:1] < b[`AGE_WIDTH:1]);
	endfunction

	// leaves sit after the internal nodes
	for (genvar i = 0; i < `QUEUE_DEPTH; i++) begin : gLeaf
		assign nodeValid[`QUEUE_DEPTH-1+i] = entryValid_i[i] & entryReady_i[i];
		assign nodeAge[`QUEUE_DEPTH-1+i]   = entryAge_i[i];
		assign nodeIdx[`QUEUE_DEPTH-1+i]   = slotIdx_t'(i);
	end

	for (genvar j = 0; j < `QUEUE_DEPTH - 1; j++) begin : gNode
		logic pickRight;
		assign pickRight = nodeValid[2*j+2] &
			(~nodeValid[2*j+1] | isOlder(nodeAge[2*j+2], nodeAge[2*j+1]));
		assign nodeValid[j] = nodeValid[2*j+1] | nodeValid[2*j+2];
		assign nodeAge[j]   = pickRight ? nodeAge[2*j+2] : nodeAge[2*j+1];
		assign nodeIdx[j]   = pickRight ? nodeIdx[2*j+2] : nodeIdx[2*j+1];
	end

	assign issue_o     = nodeValid[0];
	assign issueSlot_o = nodeIdx[0];

	assign aluOp = entryOp_i[issueSlot_o];
	assign opA   = entryA_i[issueSlot_o];
	assign opB   = entryB_i[issueSlot_o];

	// results wrap at the data width
	always_comb begin
		case (aluOp)
			opAdd: aluOut = opA + opB;
			opSub: aluOut = opA - opB;
			opAnd: aluOut = opA & opB;
			opXor: aluOut = opA ^ opB;
		endcase
	end

	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			resultValid_o <= 1'b0;
		end else begin
			resultValid_o <= issue_o;
		end
	end

	always_ff @(posedge clk) begin
		if (issue_o) begin
			resultTag_o  <= entryDest_i[issueSlot_o];
			resultData_o <= aluOut;
		end
	end

endmodule

`default_nettype wire

//--- source/opPkg.sv
`default_nettype none

`include "issueQueue_defines.svh"

package opPkg;

	// alu operations carried by each instruction
	typedef enum logic [1:0] {
		opAdd = 2'b00,
		opSub = 2'b01,
		opAnd = 2'b10,
		opXor = 2'b11
	} aluOp_e;

	// one data word, wraps modulo 2^DATA_WIDTH
	typedef logic [`DATA_WIDTH-1:0] operand_t;

endpackage

`default_nettype wire

//--- source/queuePkg.sv
`default_nettype none

`include "issueQueue_defines.svh"

package queuePkg;

	// index of an issue buffer entry
	typedef logic [$clog2(`QUEUE_DEPTH)-1:0] slotIdx_t;

	// counter in the upper bits, wrap bit in bit 0
	typedef logic [`AGE_WIDTH:0] ageTag_t;

	// source or destination register tag
	typedef logic [`TAG_WIDTH-1:0] physTag_t;

endpackage

`default_nettype wire

//--- source/resetSync.sv
`default_nettype none
`timescale 1ns/100ps

module resetSync (
	input  logic clk,
	input  logic rst_i,
	output logic rstSync_o
);

	logic rstMeta;
	logic rstHold;

	// assert at once, release two edges later
	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			rstMeta <= 1'b1;
			rstHold <= 1'b1;
		end else begin
			rstMeta <= 1'b0;
			rstHold <= rstMeta;
		end
	end

	assign rstSync_o = rstHold;

endmodule

`default_nettype wire

//--- src.f
+incdir+source
source/opPkg.sv
source/queuePkg.sv
source/resetSync.sv
source/dispatchUnit.sv
source/issueBuffer.sv
source/issueSelect.sv
source/issueCore.sv
tb/clockGen.sv
tb/issueCore_sva.sv
tb/issueCoreTb.sv

//--- tb/clockGen.sv
`default_nettype none
`timescale 1ns/100ps

module clockGen (
	output logic clk
);

	// 20 ns period
	initial begin
		clk = 1'b0;
	end

	always #10 clk = ~clk;

endmodule

`default_nettype wire

//--- tb/issueCoreTb.sv
`default_nettype none
`timescale 1ns/100ps

`include "issueQueue_defines.svh"

module issueCoreTb;

	import opPkg::*;
	import queuePkg::*;

	localparam int TIMEOUT = 40;

	logic     clk;
	logic     rst_i;
	logic     dispatch_i;
	aluOp_e   op_i;
	operand_t srcA_i;
	operand_t srcB_i;
	physTag_t srcTag_i;
	logic     srcReady_i;
	physTag_t destTag_i;
	logic     wakeup_i;
	physTag_t wakeTag_i;
	logic     full_o;
	logic     resultValid_o;
	physTag_t resultTag_o;
	operand_t resultData_o;

	integer          seed = 8;
	int              mismatches = 0;
	int              failures = 0;
	int              cycle = 0;
	int              lastCycle = 0;
	logic [10:0]     results [$];
	int              resultCycles [$];
	operand_t        predData [8];
	logic [8*24-1:0] testName;

	clockGen u_clk (.clk(clk));

	issueCore u_dut (
		.clk(clk), .rst_i(rst_i), .dispatch_i(dispatch_i), .op_i(op_i),
		.srcA_i(srcA_i), .srcB_i(srcB_i), .srcTag_i(srcTag_i),
		.srcReady_i(srcReady_i), .destTag_i(destTag_i), .wakeup_i(wakeup_i),
		.wakeTag_i(wakeTag_i), .full_o(full_o), .resultValid_o(resultValid_o),
		.resultTag_o(resultTag_o), .resultData_o(resultData_o)
	);

	function automatic operand_t aluResult(input int op, input operand_t a, input operand_t b);
		case (op)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			default: return a ^ b;
		endcase
	endfunction

	// records {tag, data} of a result pulse, strobes last one cycle
	task automatic tick();
		@(negedge clk);
		cycle++;
		if (resultValid_o === 1'b1) begin
			results.push_back({resultTag_o, resultData_o});
			resultCycles.push_back(cycle);
		end
		dispatch_i = 1'b0;
		wakeup_i   = 1'b0;
	endtask

	task automatic dispatchOne(input int op, input operand_t a, input operand_t b,
			input physTag_t src, input logic rdy, input physTag_t dest);
		op_i       = aluOp_e'(op[1:0]);
		srcA_i     = a;
		srcB_i     = b;
		srcTag_i   = src;
		srcReady_i = rdy;
		destTag_i  = dest;
		dispatch_i = 1'b1;
		predData[dest] = aluResult(op, a, b);
		tick();
	endtask

	task automatic checkResult(input physTag_t tag, input operand_t data);
		int          waited;
		logic [10:0] got;
		waited = 0;
		while (results.size() == 0 && waited < TIMEOUT) begin
			tick();
			waited++;
		end
		if (results.size() == 0) begin
			$display("%0s: timed out waiting for the result with tag %0d", testName, tag);
			failures++;
		end else begin
			got = results.pop_front();
			lastCycle = resultCycles.pop_front();
			if (got != {tag, data}) begin
				$display("Mismatch %0s: expected tag %0d data %h, actual tag %0d data %h",
					testName, tag, data, got[10:8], got[7:0]);
				mismatches++;
			end
		end
	endtask

	// ready entries back to back, results in dispatch order
	task automatic randomBurst(input int count);
		logic [10:0] exp [$];
		int          op;
		physTag_t    dest;
		int          prevCycle;
		for (int i = 0; i < count; i++) begin
			op   = $random(seed) & 3;
			dest = physTag_t'(i % 8);
			dispatchOne(op, operand_t'($random(seed)), operand_t'($random(seed)), 3'd0, 1'b1,
				dest);
			exp.push_back({dest, predData[dest]});
		end
		prevCycle = 0;
		foreach (exp[i]) begin
			checkResult(exp[i][10:8], exp[i][7:0]);
			// one result per cycle
			if (i > 0 && lastCycle != prevCycle + 1) begin
				$display("%0s: result %0d came %0d cycles after the one before it",
					testName, i, lastCycle - prevCycle);
				failures++;
			end
			prevCycle = lastCycle;
		end
	endtask

	task automatic idle(input int cycles);
		repeat (cycles) tick();
		if (results.size() != 0) begin
			$display("%0s: %0d results appeared where none was due", testName, results.size());
			failures++;
			results.delete();
			resultCycles.delete();
		end
	endtask

	task automatic resetDut();
		rst_i = 1'b1;
		repeat (3) tick();
		rst_i = 1'b0;
		repeat (3) tick();
		results.delete();
		resultCycles.delete();
	endtask

	// fill with waiting entries, reset, then wake every tag
	task automatic resetMidRun();
		int fill;
		fill = 0;
		while (full_o !== 1'b1 && fill < `QUEUE_DEPTH) begin
			dispatchOne(0, '0, '0, '0, 1'b0, '0);
			fill++;
		end
		if (full_o !== 1'b1) begin
			$display("%0s: the queue did not fill up before the reset", testName);
			failures++;
		end
		resetDut();
		for (int t = 0; t < (1 << `TAG_WIDTH); t++) begin
			wakeTag_i = physTag_t'(t);
			wakeup_i  = 1'b1;
			tick();
		end
	endtask

	initial begin
		int          fd;
		int          code;
		int          op, a, b, src, rdy, dest;
		logic [7:0]  cmd;
		logic [8*128-1:0] line;
		rst_i = 1'b1;
		dispatch_i = 1'b0;
		op_i = opAdd;
		srcA_i = '0;
		srcB_i = '0;
		srcTag_i = '0;
		srcReady_i = 1'b0;
		destTag_i = '0;
		wakeup_i = 1'b0;
		wakeTag_i = '0;
		testName = "startup";
		@(posedge clk);
		resetDut();
		fd = $fopen("tb/issueCore_cases.txt", "r");
		if (fd == 0) begin
			$display("could not open the case file");
			failures++;
		end else begin
			while ($fscanf(fd, "%s", cmd) == 1) begin
				case (cmd)
					"#": code = $fgets(line, fd);
					"t": code = $fscanf(fd, "%s", testName);
					"d": begin
						code = $fscanf(fd, "%h %h %h %h %h %h", op, a, b, src, rdy, dest);
						dispatchOne(op, operand_t'(a), operand_t'(b), physTag_t'(src),
							rdy[0], physTag_t'(dest));
					end
					"r": begin
						code = $fscanf(fd, "%h", a);
						randomBurst(a);
					end
					"q": begin
						code = $fscanf(fd, "%h %h", a, src);
						for (int i = 0; i < a; i++) begin
							dispatchOne(0, operand_t'($random(seed)), operand_t'($random(seed)),
								physTag_t'(src), 1'b0, physTag_t'(i));
						end
					end
					"w": begin
						code = $fscanf(fd, "%h", a);
						wakeTag_i = physTag_t'(a);
						wakeup_i  = 1'b1;
					end
					"v": begin
						code = $fscanf(fd, "%h %h", a, b);
						checkResult(physTag_t'(a), operand_t'(b));
					end
					"e": begin
						code = $fscanf(fd, "%h", a);
						checkResult(physTag_t'(a), predData[a[2:0]]);
					end
					"n": begin
						code = $fscanf(fd, "%h", a);
						idle(a);
					end
					"f": begin
						code = $fscanf(fd, "%h", a);
						if (full_o !== a[0]) begin
							$display("Mismatch %0s: expected full %0d, actual full %0d",
								testName, a[0], full_o);
							mismatches++;
						end
					end
					"x": resetMidRun();
					default: begin
						$display("unknown command %s in the case file", cmd);
						failures++;
						code = $fgets(line, fd);
					end
				endcase
			end
			$fclose(fd);
		end
		$display("mismatches %0d, other errors %0d", mismatches, failures);
		if (mismatches + failures == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb/issueCore_cases.txt
# t name | d op a b srcTag ready destTag | r count | q count srcTag | w tag
# v tag data | e tag (computed data) | n cycles | f full | x reset ; all hex
t opcodes
d 0 f0 25 0 1 1
v 1 15
d 1 05 09 0 1 2
v 2 fc
d 2 3c 0f 0 1 3
v 3 0c
d 3 aa 0f 0 1 4
v 4 a5
t backToBack
r 6
t wakeup
d 0 10 01 2 0 5
n 4
w 2
d 1 20 01 0 1 6
v 5 11
v 6 1f
t full
q 7 1
d 0 02 03 5 0 7
f 1
w 5
v 7 05
f 0
t midReset
x
n 5
f 0
t ageWrap
r e
d 0 01 01 7 0 0
d 0 02 02 6 0 1
w 7
v 0 02
d 0 03 03 6 0 2
w 6
e 1
e 2

//--- tb/issueCore_sva.sv
`default_nettype none
`timescale 1ns/100ps

`include "issueQueue_defines.svh"

module issueCore_sva (
	input logic clk,
	input logic rst_i,
	input logic dispatch_i,
	input logic full_o,
	input logic resultValid_o,
	input logic write_i,
	input logic issue_i
);

	localparam int OCC_WIDTH = $clog2(`QUEUE_DEPTH) + 1;

	logic                 seenDispatch;
	logic [OCC_WIDTH-1:0] occupancy;

	// remembers any dispatch since reset
	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			seenDispatch <= 1'b0;
		end else if (dispatch_i) begin
			seenDispatch <= 1'b1;
		end
	end

	// entries held, counted from writes and issues
	always_ff @(posedge clk or posedge rst_i) begin
		if (rst_i) begin
			occupancy <= '0;
		end else begin
			occupancy <= occupancy + OCC_WIDTH'(write_i) - OCC_WIDTH'(issue_i);
		end
	end

	noDispatchWhenFull: assert property (@(posedge clk) disable iff (rst_i)
		dispatch_i |-> !full_o)
		else $error("dispatch strobe while the queue is full");

	noResultWithoutDispatch: assert property (@(posedge clk) disable iff (rst_i)
		resultValid_o |-> seenDispatch)
		else $error("result pulse without any dispatch since reset");

	fullMatchesOccupancy: assert property (@(posedge clk) disable iff (rst_i)
		full_o == (occupancy == OCC_WIDTH'(`QUEUE_DEPTH)))
		else $error("full flag disagrees with the number of held entries");

endmodule

bind issueCore issueCore_sva u_sva (
	.clk           (clk),
	.rst_i         (rstSync),
	.dispatch_i    (dispatch_i),
	.full_o        (full_o),
	.resultValid_o (resultValid_o),
	.write_i       (write),
	.issue_i       (issue)
);

`default_nettype wire
